/* logic/spi_bridge_pkg.sv */
//----------------------------------------------------------
// shared widths, depths and payload types
// for the spi to can register read bridge
//----------------------------------------------------------
package spi_bridge_pkg;

   // frame lengths, counted in sclk edges
   localparam int CMD_BITS  = 24;   // id, addr, tag on mosi
   localparam int RESP_BITS = 32;   // id, addr, tag, data on miso

   // can receive register bank
   localparam int REG_DEPTH = 256;  // receive registers
   localparam int REG_AW    = 8;    // address bits used by the bank

   // bit counter covers command plus response rises
   localparam int BIT_CNT_W = $clog2(CMD_BITS + RESP_BITS + 1);

   // one spi byte, also one can register
   typedef logic [7:0] byte_t;

   // command as received, msb first
   //   [23:16] node id
   //   [15:8]  register address
   //   [7:0]   register tag
   typedef logic [CMD_BITS-1:0] cmd_t;

   // response word, msb first
   //   [31:24] node id
   //   [23:16] register address
   //   [15:8]  register tag
   //   [7:0]   register data
   typedef logic [RESP_BITS-1:0] resp_t;

endpackage

/* logic/spi_shift_reg.sv */
//----------------------------------------------------------
// parallel-load shift register, serial in and serial out
// width follows the payload type
//----------------------------------------------------------
`timescale 1ns/1ps

module spi_shift_reg import spi_bridge_pkg::*;
#(
   parameter type payload_t = byte_t  // cmd_t for rx, resp_t for tx
)
(
   input  logic     clk,
   input  logic     rst,         // sync, active low
   input  logic     load,        // parallel load strobe
   input  payload_t load_data,   // word taken on load
   input  logic     shift,       // one bit toward msb
   input  logic     serial_in,   // enters at lsb
   output logic     serial_out,  // always the msb
   output payload_t data         // current contents
);

   // load wins over shift, both take effect next cycle
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         data <= '0;  // keeps miso low out of reset
      end
      else if (load)
      begin
         data <= load_data;
      end
      else if (shift)
      begin
         // msb drops out, new bit at lsb
         data <= {data[$bits(payload_t)-2:0], serial_in};
      end
   end

   // msb first on the wire
   assign serial_out = data[$bits(payload_t)-1];

endmodule

/* logic/can_rx_regs.sv */
//----------------------------------------------------------
// can controller receive register bank
// written from the can side, read by address
//----------------------------------------------------------
`timescale 1ns/1ps

module can_rx_regs import spi_bridge_pkg::*;
(
   input  logic  clk,
   input  logic  rst,       // sync, active low
   input  logic  can_wr,    // write strobe from can side
   input  byte_t can_addr,  // register to write
   input  byte_t can_data,  // byte to write
   input  byte_t rd_addr,   // address from spi command
   output byte_t rd_data    // combinational read
);

   byte_t regs [REG_DEPTH];  // received bytes

   // one byte per can_wr, visible the next cycle
   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         for (int i = 0; i < REG_DEPTH; i++)
         begin
            regs[i] <= '0;  // bank starts empty
         end
      end
      else if (can_wr)
      begin
         regs[can_addr[REG_AW-1:0]] <= can_data;
      end
   end

   // zero-cycle read, sampled by the response buffer
   assign rd_data = regs[rd_addr[REG_AW-1:0]];

endmodule

/* logic/buffer_rec_spi_data.sv */
//----------------------------------------------------------
// response buffer
// packs id, address, tag and register data into one word
// and flags each new word with a one-cycle pulse
//----------------------------------------------------------
`timescale 1ns/1ps

module buffer_rec_spi_data import spi_bridge_pkg::*;
(
   input  logic  clk,
   input  logic  rst,            // sync, active low
   input  logic  buffer_en,      // one-cycle capture strobe
   input  byte_t spi_id_in,      // node id byte
   input  byte_t spi_select,     // register address byte
   input  byte_t spi_reg,        // register tag byte
   input  byte_t data_rec_in,    // byte from the receive bank
   output logic  end_read_miso,  // new word ready
   output resp_t data_rec_out    // {id, addr, tag, data}
);

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         data_rec_out  <= '0;
         end_read_miso <= 1'b0;
      end
      else
      begin
         end_read_miso <= buffer_en;  // follows the strobe by one cycle
         if (buffer_en)
         begin
            // id in the top byte, register data at the bottom
            data_rec_out <= {spi_id_in, spi_select, spi_reg, data_rec_in};
         end
         // otherwise hold, so an aborted frame leaves the last word
      end
   end

endmodule

/* logic/spi_read_ctrl.sv */
//----------------------------------------------------------
// spi read control
// sclk edge detect, bit count, frame phase
// rx shift, buffer strobe, tx load and tx shift
//----------------------------------------------------------
`timescale 1ns/1ps

module spi_read_ctrl import spi_bridge_pkg::*;
(
   input  logic clk,
   input  logic rst,            // sync, active low
   input  logic sclk,           // spi clock, mode 0
   input  logic cs_n,           // frame select, low active
   input  logic end_read_miso,  // response word ready
   output logic rx_shift,       // take mosi into command
   output logic buffer_en,      // capture command and data
   output logic tx_load,        // load response into tx shifter
   output logic tx_shift        // next response bit on miso
);

   // one pass through the phases per frame
   typedef enum logic [2:0]
   {
      PH_IDLE,    // cs_n high, or first cycle of a frame
      PH_CMD,     // receiving the 24 command bits
      PH_STROBE,  // waiting for the buffer to fill
      PH_RESP,    // shifting the response out
      PH_DONE     // all bits sent, wait for cs_n
   } phase_t;

   phase_t               phase;
   logic                 sclk_q;         // sclk one cycle late
   logic                 sclk_rise;
   logic                 sclk_fall;
   logic [BIT_CNT_W-1:0] bit_cnt;        // sclk rises in this frame
   logic                 cmd_phase;      // command bits still expected
   logic                 last_cmd_bit;   // 24th rise
   logic                 last_resp_bit;  // 32nd response shift

   always_ff @(posedge clk)
   begin
      if (!rst)
         sclk_q <= 1'b0;  // mode 0 idles low
      else
         sclk_q <= sclk;
   end

   assign sclk_rise = sclk & ~sclk_q;
   assign sclk_fall = ~sclk & sclk_q;

   // a rise in the idle cycle still counts once cs_n is low
   assign cmd_phase    = (phase == PH_IDLE) || (phase == PH_CMD);
   assign rx_shift     = sclk_rise & ~cs_n & cmd_phase;
   assign last_cmd_bit = rx_shift && (bit_cnt == BIT_CNT_W'(CMD_BITS - 1));

   // load in the same cycle the buffer reports its new word
   assign tx_load = end_read_miso & ~cs_n & (phase == PH_STROBE);

   // the fall right after the 24th rise keeps bit 31 on miso,
   // shifting starts once the host has sampled it
   assign tx_shift = sclk_fall & ~cs_n & (phase == PH_RESP)
                   & (bit_cnt != BIT_CNT_W'(CMD_BITS));
   assign last_resp_bit = tx_shift
                        && (bit_cnt == BIT_CNT_W'(CMD_BITS + RESP_BITS));

   always_ff @(posedge clk)
   begin
      if (!rst)
      begin
         phase     <= PH_IDLE;
         bit_cnt   <= '0;
         buffer_en <= 1'b0;
      end
      else if (cs_n)
      begin
         // end of frame or abort
         phase     <= PH_IDLE;
         bit_cnt   <= '0;
         buffer_en <= 1'b0;
      end
      else
      begin
         buffer_en <= last_cmd_bit;  // one cycle after the 24th rise

         if (sclk_rise && (phase != PH_DONE))
            bit_cnt <= bit_cnt + 1'b1;  // max 56, fits BIT_CNT_W

         case (phase)
            PH_IDLE:
            begin
               phase <= PH_CMD;
            end
            PH_CMD:
            begin
               if (last_cmd_bit)
                  phase <= PH_STROBE;
            end
            PH_STROBE:
            begin
               if (tx_load)
                  phase <= PH_RESP;
            end
            PH_RESP:
            begin
               if (last_resp_bit)
                  phase <= PH_DONE;  // shifter now all zero
            end
            PH_DONE:
            begin
               phase <= PH_DONE;  // hold until cs_n rises
            end
            default:
            begin
               phase <= PH_IDLE;
            end
         endcase
      end
   end

endmodule

/* logic/spi_can_bridge.sv */
//----------------------------------------------------------
// spi to can register read bridge, top level
// control, command and response shifters,
// receive register bank and response buffer
//----------------------------------------------------------
`timescale 1ns/1ps

module spi_can_bridge import spi_bridge_pkg::*;
(
   input  logic  clk,
   input  logic  rst,            // sync, active low
   input  logic  sclk,           // spi clock, mode 0
   input  logic  cs_n,           // frame select
   input  logic  mosi,           // command in, msb first
   output logic  miso,           // response out, msb first
   input  logic  can_wr,         // can side register write
   input  byte_t can_addr,
   input  byte_t can_data,
   output logic  end_read_miso,  // one-cycle done pulse
   output resp_t data_rec_out    // parallel response word
);

   logic  rx_shift;
   logic  buffer_en;
   logic  tx_load;
   logic  tx_shift;
   cmd_t  cmd_word;  // received command bits
   byte_t cmd_id;
   byte_t cmd_addr;
   byte_t cmd_tag;
   byte_t reg_data;  // bank read at cmd_addr

   // command bytes in arrival order
   assign cmd_id   = cmd_word[CMD_BITS-1 -: 8];
   assign cmd_addr = cmd_word[CMD_BITS-9 -: 8];
   assign cmd_tag  = cmd_word[7:0];

   spi_read_ctrl spi_read_ctrl_i (
      .clk           (clk),
      .rst           (rst),
      .sclk          (sclk),
      .cs_n          (cs_n),
      .end_read_miso (end_read_miso),
      .rx_shift      (rx_shift),
      .buffer_en     (buffer_en),
      .tx_load       (tx_load),
      .tx_shift      (tx_shift)
   );

   // command shifter, serial only
   spi_shift_reg #(.payload_t(cmd_t)) rx_shift_reg_i (
      .clk        (clk),
      .rst        (rst),
      .load       (1'b0),
      .load_data  ('0),
      .shift      (rx_shift),
      .serial_in  (mosi),
      .serial_out (),
      .data       (cmd_word)
   );

   can_rx_regs can_rx_regs_i (
      .clk      (clk),
      .rst      (rst),
      .can_wr   (can_wr),
      .can_addr (can_addr),
      .can_data (can_data),
      .rd_addr  (cmd_addr),
      .rd_data  (reg_data)
   );

   buffer_rec_spi_data buffer_rec_spi_data_i (
      .clk           (clk),
      .rst           (rst),
      .buffer_en     (buffer_en),
      .spi_id_in     (cmd_id),
      .spi_select    (cmd_addr),
      .spi_reg       (cmd_tag),
      .data_rec_in   (reg_data),
      .end_read_miso (end_read_miso),
      .data_rec_out  (data_rec_out)
   );

   // response shifter, zeros fill in behind the last bit
   spi_shift_reg #(.payload_t(resp_t)) tx_shift_reg_i (
      .clk        (clk),
      .rst        (rst),
      .load       (tx_load),
      .load_data  (data_rec_out),
      .shift      (tx_shift),
      .serial_in  (1'b0),
      .serial_out (miso),
      .data       ()
   );

endmodule

/* verif/spi_can_bridge_asserts.sv */
//----------------------------------------------------------
// bound assertions for the spi to can bridge
// reset state, done pulse shape and timing, first miso bit
//----------------------------------------------------------
`timescale 1ns/1ps

module spi_can_bridge_asserts import spi_bridge_pkg::*;
(
   input logic  clk,
   input logic  rst,
   input logic  last_cmd_bit,   // 24th sclk rise seen by control
   input logic  end_read_miso,
   input logic  miso,
   input resp_t data_rec_out
);

   int fail_cnt = 0;  // failed assertions so far

   // outputs quiet one cycle into reset
   a_reset_state: assert property (@(posedge clk)
      !rst |=> (data_rec_out == '0 && !end_read_miso && !miso))
      else
      begin
         fail_cnt++;
         $error("outputs not cleared by reset");
      end

   a_pulse_width: assert property (@(posedge clk) disable iff (!rst)
      end_read_miso |=> !end_read_miso)
      else
      begin
         fail_cnt++;
         $error("end_read_miso longer than one cycle");
      end

   // done two cycles after the last command bit, and only then
   a_pulse_after_cmd: assert property (@(posedge clk) disable iff (!rst)
      last_cmd_bit |-> ##2 end_read_miso)
      else
      begin
         fail_cnt++;
         $error("no end_read_miso 2 cycles after bit 24");
      end

   a_pulse_cause: assert property (@(posedge clk) disable iff (!rst)
      end_read_miso |-> $past(last_cmd_bit, 2))
      else
      begin
         fail_cnt++;
         $error("end_read_miso without a full command");
      end

   a_word_hold: assert property (@(posedge clk) disable iff (!rst)
      !end_read_miso |-> $stable(data_rec_out))
      else
      begin
         fail_cnt++;
         $error("data_rec_out changed without done pulse");
      end

   // response msb on miso once the tx shifter has loaded
   a_first_bit: assert property (@(posedge clk) disable iff (!rst)
      end_read_miso |=> miso == data_rec_out[RESP_BITS-1])
      else
      begin
         fail_cnt++;
         $error("miso does not carry response bit 31 after load");
      end

endmodule

/* verif/tb_spi_can_bridge.sv */
//----------------------------------------------------------
// testbench for the spi to can register read bridge
// clock, reset, can writes, spi host frames, reference memory
//----------------------------------------------------------
`timescale 1ns/1ps

module tb_spi_can_bridge import spi_bridge_pkg::*;;

   localparam int N_FRAMES     = 10;                // full and aborted frames
   localparam int FRAME_CYCLES = (CMD_BITS + RESP_BITS) * 10 + 16;
   localparam int LIMIT        = N_FRAMES * FRAME_CYCLES + 400;

   logic  clk = 1'b0;
   logic  rst, sclk, cs_n, mosi, miso, can_wr, end_read_miso;
   byte_t can_addr, can_data;
   resp_t data_rec_out;

   byte_t       ref_mem [REG_DEPTH];  // mirror of the receive bank
   byte_t       wr_addr [8];          // addresses written so far
   resp_t       exp_word;
   string       test_name;
   int          errors    = 0;
   int          pulse_cnt = 0;        // end_read_miso pulses seen
   logic [31:0] seed      = 32'd93;

   always #5 clk = ~clk;

   spi_can_bridge spi_can_bridge_i (.*);

   bind spi_can_bridge spi_can_bridge_asserts asserts_i (
      .clk           (clk),
      .rst           (rst),
      .last_cmd_bit  (spi_read_ctrl_i.last_cmd_bit),
      .end_read_miso (end_read_miso),
      .miso          (miso),
      .data_rec_out  (data_rec_out)
   );

   function automatic byte_t rand_byte();
      seed = seed * 32'd1103515245 + 32'd12345;  // lcg step
      return seed[23:16];                        // middle byte of the state
   endfunction

   // parallel word checked in the cycle the done pulse is high
   always @(negedge clk)
   begin
      if (rst && end_read_miso)
      begin
         pulse_cnt++;
         assert (data_rec_out == exp_word)
         else
         begin
            errors++;
            $display("MISMATCH %s parallel expected %h actual %h", test_name, exp_word,
                     data_rec_out);
         end
      end
   end

   task automatic can_write(input byte_t a, input byte_t d);
      @(posedge clk);
      can_wr   <= 1'b1;
      can_addr <= a;
      can_data <= d;
      @(posedge clk);
      can_wr   <= 1'b0;
      ref_mem[a] = d;  // bank takes it at this edge
   endtask

   // one mode 0 bit with miso sampled just before the rise
   task automatic spi_bit(input logic b, output logic s);
      @(posedge clk) mosi <= b;
      repeat (3) @(posedge clk);
      @(negedge clk) s = miso;
      @(posedge clk) sclk <= 1'b1;
      repeat (4) @(posedge clk);
      sclk <= 1'b0;
   endtask

   task automatic run_frame(input string name, input byte_t id, input byte_t a,
                            input byte_t tag, input int nbits);
      cmd_t        cmd;
      logic [31:0] rx;
      logic        s;
      int          pulses_before;
      resp_t       prev_word;
      cmd           = {id, a, tag};
      rx            = '0;
      test_name     = name;
      exp_word      = {id, a, tag, ref_mem[a]};  // mirror byte at the read address
      pulses_before = pulse_cnt;
      prev_word     = data_rec_out;
      @(posedge clk) cs_n <= 1'b0;
      repeat (2) @(posedge clk);
      for (int i = 0; i < nbits; i++)
      begin
         spi_bit((i < CMD_BITS) ? cmd[CMD_BITS-1-i] : 1'b0, s);
         if (i >= CMD_BITS)
            rx = {rx[30:0], s};  // msb arrives first
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      if (nbits == CMD_BITS + RESP_BITS)
      begin
         assert (rx == exp_word)
         else
         begin
            errors++;
            $display("MISMATCH %s serial expected %h actual %h", name, exp_word, rx);
         end
         assert (miso == 1'b0)
         else
         begin
            errors++;
            $display("MISMATCH %s miso after last bit expected 0 actual %b", name, miso);
         end
         assert (pulse_cnt == pulses_before + 1)
         else
         begin
            errors++;
            $display("%s: expected exactly one done pulse, saw %0d", name,
                     pulse_cnt - pulses_before);
         end
      end
      else
      begin
         assert (pulse_cnt == pulses_before)
         else
         begin
            errors++;
            $display("%s: aborted frame still raised end_read_miso", name);
         end
         assert (data_rec_out == prev_word)
         else
         begin
            errors++;
            $display("MISMATCH %s held word expected %h actual %h", name, prev_word,
                     data_rec_out);
         end
      end
      @(posedge clk) cs_n <= 1'b1;
      repeat (4) @(posedge clk);  // idle gap between frames
   endtask

   initial
   begin
      byte_t a;
      rst      = 1'b0;
      sclk     = 1'b0;
      cs_n     = 1'b1;
      mosi     = 1'b0;
      can_wr   = 1'b0;
      can_addr = '0;
      can_data = '0;
      for (int i = 0; i < REG_DEPTH; i++)
         ref_mem[i] = '0;  // bank clears on reset
      repeat (5) @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
      assert (data_rec_out == '0 && !end_read_miso && !miso)
      else
      begin
         errors++;
         // word, done, miso
         $display("MISMATCH reset_state expected 0/0/0 actual %h/%b/%b", data_rec_out,
                  end_read_miso, miso);
      end
      for (int i = 0; i < 8; i++)
      begin
         wr_addr[i] = rand_byte();
         can_write(wr_addr[i], rand_byte());
      end
      for (int i = 0; i < 6; i++)
         run_frame("random_read", rand_byte(), wr_addr[rand_byte() & 8'h7], rand_byte(),
                   CMD_BITS + RESP_BITS);
      run_frame("abort", rand_byte(), wr_addr[0], rand_byte(), 10);
      run_frame("after_abort", rand_byte(), wr_addr[1], rand_byte(), CMD_BITS + RESP_BITS);
      a = wr_addr[2];
      run_frame("update_before", rand_byte(), a, rand_byte(), CMD_BITS + RESP_BITS);
      can_write(a, ~ref_mem[a]);  // new byte always differs
      run_frame("update_after", rand_byte(), a, rand_byte(), CMD_BITS + RESP_BITS);
      $display("tb errors %0d, assertion failures %0d", errors,
               spi_can_bridge_i.asserts_i.fail_cnt);
      if (errors == 0 && spi_can_bridge_i.asserts_i.fail_cnt == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   // bound on total frame time plus setup
   initial
   begin
      repeat (LIMIT) @(posedge clk);
      $display("timeout: frames did not complete within %0d cycles", LIMIT);
      $display("Done: errors found");
      $finish;
   end

endmodule

/* verilog.f */
logic/spi_bridge_pkg.sv
logic/spi_shift_reg.sv
logic/can_rx_regs.sv
logic/buffer_rec_spi_data.sv
logic/spi_read_ctrl.sv
logic/spi_can_bridge.sv
verif/spi_can_bridge_asserts.sv
verif/tb_spi_can_bridge.sv
